/* tests/cache_input.txt */
# Columns (hex): op(0 read,1 write) addr wdata parent_delay exp_rdata exp_error stall
# then exp_parent, the number of parent requests; delay ff means the parent never answers.
0 0012 00000000 03 0012ffed 0 0 1
0 0012 00000000 03 0012ffed 0 0 0
1 0012 deadbeef 00 00000000 0 0 1
0 0012 00000000 03 deadbeef 0 0 0
1 0045 12345678 00 00000000 0 0 1
0 0045 00000000 02 12345678 0 0 1
0 0045 00000000 02 12345678 0 0 0
0 0115 00000000 01 0115feea 0 0 1
0 0045 00000000 04 12345678 0 0 1
0 0115 00000000 00 0115feea 0 0 1
0 0100 00000000 ff 00000000 1 0 1
0 0100 00000000 02 0100feff 0 0 1
0 0100 00000000 02 0100feff 0 0 0
0 0012 00000000 00 deadbeef 0 1 0
0 0233 00000000 05 0233fdcc 0 1 1
1 0233 cafef00d 00 00000000 0 0 1
0 0233 00000000 00 cafef00d 0 0 0
0 0abc 00000000 00 0abcf543 0 0 1
0 0abc 00000000 00 0abcf543 0 0 0
0 1abc 00000000 07 1abce543 0 0 1
0 0abc 00000000 01 0abcf543 0 0 1
1 1abc 0badcafe 00 00000000 0 0 1
0 1abc 00000000 02 0badcafe 0 0 1
0 0abc 00000000 04 0abcf543 0 1 1
0 ffff 00000000 03 ffff0000 0 0 1
0 ffff 00000000 03 ffff0000 0 0 0
0 0000 00000000 00 0000ffff 0 0 1
0 0000 00000000 00 0000ffff 0 1 0

/* cache_top.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/cache_decode.sv
hdl/cache_encode.sv
hdl/cache_control_fsm.sv
hdl/cache_fill_timer.sv
hdl/cache_top.sv
tests/cache_checker.sv
tests/cache_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module cache_top_tb -f cache_top.f -o cache_sim
./obj_dir/cache_sim 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
else
    exit 1
fi

/* tests/cache_top_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_top_tb;

    localparam int MAX_TESTS = 64;

    logic                         clk;
    logic                         rst;
    logic                         req_valid;
    logic                         req_ready;
    cache_pkg::cache_op_t         req_op;
    logic [`CACHE_ADDR_WIDTH-1:0] req_addr;
    logic [`CACHE_DATA_WIDTH-1:0] req_wdata;
    logic                         resp_valid;
    logic                         resp_ready;
    logic [`CACHE_DATA_WIDTH-1:0] resp_rdata;
    logic                         resp_error;
    logic                         parent_req_valid;
    logic                         parent_req_ready;
    cache_pkg::cache_op_t         parent_req_op;
    logic [`CACHE_ADDR_WIDTH-1:0] parent_req_addr;
    logic [`CACHE_DATA_WIDTH-1:0] parent_req_wdata;
    logic                         parent_resp_valid = 1'b0;
    logic [`CACHE_DATA_WIDTH-1:0] parent_resp_rdata = '0;

    // Test table filled from the data file.
    logic                         t_op     [MAX_TESTS];
    logic [`CACHE_ADDR_WIDTH-1:0] t_addr   [MAX_TESTS];
    logic [`CACHE_DATA_WIDTH-1:0] t_wdata  [MAX_TESTS];
    logic [7:0]                   t_delay  [MAX_TESTS];
    logic [`CACHE_DATA_WIDTH-1:0] t_rdata  [MAX_TESTS];
    logic                         t_err    [MAX_TESTS];
    logic                         t_stall  [MAX_TESTS];
    logic [3:0]                   t_parent [MAX_TESTS];
    int                           num_tests;

    // Current test as seen by the checker and the parent model.
    int                           cur_test;
    cache_pkg::cache_op_t         cur_op;
    logic [`CACHE_ADDR_WIDTH-1:0] cur_addr;
    logic [`CACHE_DATA_WIDTH-1:0] cur_wdata;
    logic [7:0]                   cur_delay;
    logic [`CACHE_DATA_WIDTH-1:0] cur_rdata;
    logic                         cur_err;
    logic [3:0]                   cur_parent;
    logic                         test_end;

    int cycle_count;
    int cycle_limit;
    int tests_run;
    int tests_failed;

    cache_top UUT (
        .clk, .rst,
        .req_valid, .req_ready, .req_op, .req_addr, .req_wdata,
        .resp_valid, .resp_ready, .resp_rdata, .resp_error,
        .parent_req_valid, .parent_req_ready, .parent_req_op, .parent_req_addr,
        .parent_req_wdata,
        .parent_resp_valid, .parent_resp_rdata
    );

    cache_checker checker_inst (
        .clk, .rst,
        .test_num(cur_test), .test_end,
        .exp_op(cur_op), .exp_addr(cur_addr), .exp_wdata(cur_wdata),
        .exp_rdata(cur_rdata), .exp_error(cur_err), .exp_parent(cur_parent),
        .resp_valid, .resp_ready, .resp_rdata, .resp_error,
        .parent_req_valid, .parent_req_ready, .parent_req_op, .parent_req_addr,
        .parent_req_wdata,
        .tests_run, .tests_failed
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **********************************************************************
    // Parent memory model
    // **********************************************************************

    logic [`CACHE_DATA_WIDTH-1:0] written [logic [`CACHE_ADDR_WIDTH-1:0]];
    logic                         pending;
    logic [7:0]                   countdown;
    logic [`CACHE_ADDR_WIDTH-1:0] pending_addr;

    function automatic logic [`CACHE_DATA_WIDTH-1:0] memory_pattern(
        input logic [`CACHE_ADDR_WIDTH-1:0] a);
        return {a, ~a}; // Unique per address.
    endfunction

    always @(posedge clk) begin
        parent_resp_valid <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
        end else begin
            if (parent_req_valid && parent_req_ready) begin
                if (parent_req_op == cache_pkg::CACHE_OP_WRITE) begin
                    written[parent_req_addr] = parent_req_wdata;
                end else if (cur_delay != 8'hff) begin // ff never answers.
                    pending      <= 1'b1;
                    countdown    <= cur_delay;
                    pending_addr <= parent_req_addr;
                end
            end
            if (pending) begin
                if (countdown == 8'd0) begin
                    parent_resp_valid <= 1'b1;
                    parent_resp_rdata <= written.exists(pending_addr) ?
                                         written[pending_addr] : memory_pattern(pending_addr);
                    pending <= 1'b0;
                end else begin
                    countdown <= countdown - 8'd1;
                end
            end
        end
    end

    initial begin
        parent_req_ready = 1'b1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // **********************************************************************
    // Stimulus
    // **********************************************************************

    task automatic read_tests();
        int    fd;
        string line;
        int    op, addr, wdata, delay, rdata, err, stall, parent;
        fd = $fopen("tests/cache_input.txt", "r");
        num_tests = 0;
        if (fd == 0) begin
            $display("Could not open tests/cache_input.txt");
            return;
        end
        while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h %h %h %h %h",
                        op, addr, wdata, delay, rdata, err, stall, parent) == 8) begin
                t_op[num_tests]     = op[0];
                t_addr[num_tests]   = addr[`CACHE_ADDR_WIDTH-1:0];
                t_wdata[num_tests]  = wdata;
                t_delay[num_tests]  = delay[7:0];
                t_rdata[num_tests]  = rdata;
                t_err[num_tests]    = err[0];
                t_stall[num_tests]  = stall[0];
                t_parent[num_tests] = parent[3:0];
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int i);
        @(posedge clk);
        cur_test   <= i + 1;
        cur_op     <= cache_pkg::cache_op_t'(t_op[i]);
        cur_addr   <= t_addr[i];
        cur_wdata  <= t_wdata[i];
        cur_delay  <= t_delay[i];
        cur_rdata  <= t_rdata[i];
        cur_err    <= t_err[i];
        cur_parent <= t_parent[i];
        req_valid  <= 1'b1;
        req_op     <= cache_pkg::cache_op_t'(t_op[i]);
        req_addr   <= t_addr[i];
        req_wdata  <= t_wdata[i];
        resp_ready <= !t_stall[i];
        do @(posedge clk); while (!(req_valid && req_ready));
        req_valid <= 1'b0;
        if (t_op[i] == 1'b0) begin
            if (t_stall[i]) begin
                do @(posedge clk); while (!resp_valid);
                repeat (4) @(posedge clk);
                resp_ready <= 1'b1;
            end
            do @(posedge clk); while (!(resp_valid && resp_ready));
        end else begin
            while (!(parent_req_valid && parent_req_ready &&
                     parent_req_op == cache_pkg::CACHE_OP_WRITE)) begin
                @(posedge clk);
            end
        end
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op      = cache_pkg::CACHE_OP_READ;
        req_addr    = '0;
        req_wdata   = '0;
        resp_ready  = 1'b1;
        test_end    = 1'b0;
        cur_test    = 0;
        cur_op      = cache_pkg::CACHE_OP_READ;
        cur_addr    = '0;
        cur_wdata   = '0;
        cur_delay   = 8'd0;
        cur_rdata   = '0;
        cur_err     = 1'b0;
        cur_parent  = 4'd0;
        cycle_count = 0;
        cycle_limit = 0;
        read_tests();
        cycle_limit = num_tests * (`CACHE_FILL_TIMEOUT + 300);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        repeat (5) @(posedge clk);
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (num_tests > 0 && tests_failed == 0 && tests_run == num_tests) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/cache_checker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  int                           test_num,
    input  logic                         test_end,
    input  cache_pkg::cache_op_t         exp_op,
    input  logic [`CACHE_ADDR_WIDTH-1:0] exp_addr,
    input  logic [`CACHE_DATA_WIDTH-1:0] exp_wdata,
    input  logic [`CACHE_DATA_WIDTH-1:0] exp_rdata,
    input  logic                         exp_error,
    input  logic [3:0]                   exp_parent,
    input  logic                         resp_valid,
    input  logic                         resp_ready,
    input  logic [`CACHE_DATA_WIDTH-1:0] resp_rdata,
    input  logic                         resp_error,
    input  logic                         parent_req_valid,
    input  logic                         parent_req_ready,
    input  cache_pkg::cache_op_t         parent_req_op,
    input  logic [`CACHE_ADDR_WIDTH-1:0] parent_req_addr,
    input  logic [`CACHE_DATA_WIDTH-1:0] parent_req_wdata,
    output int                           tests_run,
    output int                           tests_failed
);

    int                           resp_count;
    int                           parent_count;
    int                           cur_fail;
    int                           exp_resp;
    logic                         was_stalled;
    logic [`CACHE_DATA_WIDTH-1:0] held_rdata;
    logic                         held_error;

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        resp_count   = 0;
        parent_count = 0;
        cur_fail     = 0;
        was_stalled  = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            // Stalled response must not move.
            if (was_stalled && (!resp_valid || resp_rdata != held_rdata ||
                                resp_error != held_error)) begin
                $display("test_%0d: response changed while resp_ready was low", test_num);
                cur_fail++;
            end
            was_stalled = resp_valid && !resp_ready;
            held_rdata  = resp_rdata;
            held_error  = resp_error;

            if (resp_valid && resp_ready) begin
                resp_count++;
                if (exp_op == cache_pkg::CACHE_OP_WRITE) begin
                    $display("test_%0d: child response seen for a write", test_num);
                    cur_fail++;
                end else begin
                    if (resp_rdata !== exp_rdata) begin
                        $display("ERROR test_%0d rdata: expected %h, actual %h",
                                 test_num, exp_rdata, resp_rdata);
                        cur_fail++;
                    end
                    if (resp_error !== exp_error) begin
                        $display("ERROR test_%0d resp_error: expected %b, actual %b",
                                 test_num, exp_error, resp_error);
                        cur_fail++;
                    end
                end
            end

            if (parent_req_valid && parent_req_ready) begin
                parent_count++;
                if (parent_req_op !== exp_op) begin
                    $display("ERROR test_%0d parent op: expected %0d, actual %0d",
                             test_num, exp_op, parent_req_op);
                    cur_fail++;
                end
                if (parent_req_addr !== exp_addr) begin
                    $display("ERROR test_%0d parent addr: expected %h, actual %h",
                             test_num, exp_addr, parent_req_addr);
                    cur_fail++;
                end
                if (exp_op == cache_pkg::CACHE_OP_WRITE && parent_req_wdata !== exp_wdata) begin
                    $display("ERROR test_%0d parent wdata: expected %h, actual %h",
                             test_num, exp_wdata, parent_req_wdata);
                    cur_fail++;
                end
            end

            // **************************************************************
            // End of test
            // **************************************************************
            if (test_end) begin
                exp_resp = (exp_op == cache_pkg::CACHE_OP_READ) ? 1 : 0;
                if (resp_count != exp_resp) begin
                    $display("ERROR test_%0d child responses: expected %0d, actual %0d",
                             test_num, exp_resp, resp_count);
                    cur_fail++;
                end
                if (parent_count != int'(exp_parent)) begin
                    $display("ERROR test_%0d parent requests: expected %0d, actual %0d",
                             test_num, exp_parent, parent_count);
                    cur_fail++;
                end
                $display("test_%0d %s addr %h: %s", test_num,
                         (exp_op == cache_pkg::CACHE_OP_READ) ? "read" : "write",
                         exp_addr, (cur_fail == 0) ? "PASS" : "FAIL");
                tests_run++;
                if (cur_fail != 0) tests_failed++;
                resp_count   = 0;
                parent_count = 0;
                cur_fail     = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_top (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          req_valid,
    output logic                          req_ready,
    input  cache_pkg::cache_op_t          req_op,
    input  logic [`CACHE_ADDR_WIDTH-1:0]  req_addr,
    input  logic [`CACHE_DATA_WIDTH-1:0]  req_wdata,

    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [`CACHE_DATA_WIDTH-1:0]  resp_rdata,
    output logic                          resp_error,

    output logic                          parent_req_valid,
    input  logic                          parent_req_ready,
    output cache_pkg::cache_op_t          parent_req_op,
    output logic [`CACHE_ADDR_WIDTH-1:0]  parent_req_addr,
    output logic [`CACHE_DATA_WIDTH-1:0]  parent_req_wdata,

    input  logic                          parent_resp_valid,
    input  logic [`CACHE_DATA_WIDTH-1:0]  parent_resp_rdata
);

    logic [`CACHE_INDEX_BITS-1:0] read_index;
    logic [`CACHE_TAG_BITS-1:0]   read_tag;
    logic                         read_valid_bit;
    logic [`CACHE_DATA_WIDTH-1:0] read_data;

    logic                         stage_valid, stage_hit, stage_hold;
    cache_pkg::cache_op_t         stage_op;
    logic [`CACHE_ADDR_WIDTH-1:0] stage_addr;
    logic [`CACHE_DATA_WIDTH-1:0] stage_wdata;

    logic accept_enable, fill_write, resp_from_fill, resp_timeout, timer_run, timeout;
    logic write_hit_update, resp_done, parent_done;
    logic                         store_write;
    logic [`CACHE_DATA_WIDTH-1:0] store_wdata;

    // Store writes come from a fill or a write hit, both at the staged address.
    assign store_write = fill_write || write_hit_update;
    assign store_wdata = fill_write ? parent_resp_rdata : stage_wdata;

    cache_decode decode_inst (
        .clk, .rst,
        .req_valid, .req_op, .req_addr, .req_wdata, .req_ready,
        .accept_enable,
        .read_index, .read_tag, .read_valid_bit,
        .stage_valid, .stage_op, .stage_addr, .stage_wdata, .stage_hit,
        .stage_hold
    );

    cache_store store_inst (
        .clk, .rst,
        .read_index, .read_tag, .read_valid_bit, .read_data,
        .write_enable(store_write),
        .write_index(stage_addr[`CACHE_INDEX_BITS-1:0]),
        .write_tag(stage_addr[`CACHE_ADDR_WIDTH-1:`CACHE_INDEX_BITS]),
        .write_data(store_wdata)
    );

    cache_encode encode_inst (
        .clk, .rst,
        .stage_valid, .stage_op, .stage_addr, .stage_wdata, .stage_hit, .read_data,
        .resp_from_fill, .resp_timeout, .parent_resp_rdata,
        .resp_valid, .resp_rdata, .resp_error, .resp_ready, .resp_done,
        .parent_req_valid, .parent_req_op, .parent_req_addr, .parent_req_wdata,
        .parent_req_ready, .parent_done,
        .write_hit_update, .stage_hold
    );

    cache_control_fsm control_inst (
        .clk, .rst,
        .stage_valid, .stage_op, .stage_hit, .parent_done, .parent_resp_valid,
        .timeout, .resp_done,
        .accept_enable, .fill_write, .resp_from_fill, .resp_timeout, .timer_run
    );

    cache_fill_timer timer_inst (
        .clk, .rst,
        .timer_run,
        .timeout
    );

endmodule

`default_nettype wire

/* hdl/cache_fill_timer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_fill_timer (
    input  logic clk,
    input  logic rst,
    input  logic timer_run,
    output logic timeout
);

    localparam int COUNT_BITS = $clog2(`CACHE_FILL_TIMEOUT + 1);

    logic [COUNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || !timer_run) begin
            count <= '0;
        end else if (!timeout) begin
            count <= count + 1'b1; // Saturates at the limit.
        end
    end

    assign timeout = (count == COUNT_BITS'(`CACHE_FILL_TIMEOUT));

endmodule

`default_nettype wire

/* hdl/cache_control_fsm.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_control_fsm (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 stage_valid,
    input  cache_pkg::cache_op_t stage_op,
    input  logic                 stage_hit,
    input  logic                 parent_done,
    input  logic                 parent_resp_valid,
    input  logic                 timeout,
    input  logic                 resp_done,

    output logic                 accept_enable,
    output logic                 fill_write,
    output logic                 resp_from_fill,
    output logic                 resp_timeout,
    output logic                 timer_run
);

    cache_pkg::cache_state_t state, state_next;
    logic staged_write, staged_miss;

    assign staged_write = stage_valid && (stage_op == cache_pkg::CACHE_OP_WRITE);
    assign staged_miss  = stage_valid && (stage_op == cache_pkg::CACHE_OP_READ) && !stage_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::STATE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::STATE_IDLE: begin
                if (staged_write) begin
                    state_next = cache_pkg::STATE_PARENT_WRITE;
                end else if (staged_miss) begin
                    state_next = cache_pkg::STATE_PARENT_READ;
                end
            end
            cache_pkg::STATE_PARENT_WRITE: begin
                if (parent_done) state_next = cache_pkg::STATE_IDLE;
            end
            cache_pkg::STATE_PARENT_READ: begin
                if (parent_done) state_next = cache_pkg::STATE_FILL_WAIT;
            end
            cache_pkg::STATE_FILL_WAIT: begin
                if (parent_resp_valid || timeout) state_next = cache_pkg::STATE_IDLE;
            end
            default: state_next = cache_pkg::STATE_IDLE;
        endcase
    end

    // No new request behind a write or a miss.
    assign accept_enable = (state == cache_pkg::STATE_IDLE) && !staged_write && !staged_miss;

    assign timer_run      = (state == cache_pkg::STATE_FILL_WAIT);
    assign fill_write     = timer_run && parent_resp_valid;
    assign resp_from_fill = fill_write;
    assign resp_timeout   = timer_run && !parent_resp_valid && timeout;

    // Nothing is staged or answered while a fill is pending.
    assert property (@(posedge clk) disable iff (rst)
        timer_run |-> !stage_valid && !resp_done)
        else $error("Request staged or response taken during fill wait.");

endmodule

`default_nettype wire

/* hdl/cache_encode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_encode (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          stage_valid,
    input  cache_pkg::cache_op_t          stage_op,
    input  logic [`CACHE_ADDR_WIDTH-1:0]  stage_addr,
    input  logic [`CACHE_DATA_WIDTH-1:0]  stage_wdata,
    input  logic                          stage_hit,
    input  logic [`CACHE_DATA_WIDTH-1:0]  read_data,

    input  logic                          resp_from_fill,
    input  logic                          resp_timeout,
    input  logic [`CACHE_DATA_WIDTH-1:0]  parent_resp_rdata,

    output logic                          resp_valid,
    output logic [`CACHE_DATA_WIDTH-1:0]  resp_rdata,
    output logic                          resp_error,
    input  logic                          resp_ready,
    output logic                          resp_done,

    output logic                          parent_req_valid,
    output cache_pkg::cache_op_t          parent_req_op,
    output logic [`CACHE_ADDR_WIDTH-1:0]  parent_req_addr,
    output logic [`CACHE_DATA_WIDTH-1:0]  parent_req_wdata,
    input  logic                          parent_req_ready,
    output logic                          parent_done,

    output logic                          write_hit_update,
    output logic                          stage_hold
);

    logic is_write;
    logic resp_free, parent_free;
    logic produce_resp, produce_parent;
    logic load_resp;

    assign is_write    = (stage_op == cache_pkg::CACHE_OP_WRITE);
    assign resp_free   = !resp_valid || resp_ready;
    assign parent_free = !parent_req_valid || parent_req_ready;

    // One product per staged request.
    assign produce_resp = stage_valid && !is_write && stage_hit && resp_free;

    // A miss also waits for an empty response slot, so the fill never collides.
    assign produce_parent = stage_valid && (is_write || !stage_hit) &&
                            parent_free && (is_write || resp_free);

    assign write_hit_update = produce_parent && is_write && stage_hit;
    assign stage_hold       = stage_valid && !(produce_resp || produce_parent);

    assign resp_done   = resp_valid && resp_ready;
    assign parent_done = parent_req_valid && parent_req_ready;

    // **********************************************************************
    // Child response register
    // **********************************************************************

    assign load_resp = produce_resp || resp_from_fill || resp_timeout;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (load_resp) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_resp) begin
            if (resp_from_fill) begin
                resp_rdata <= parent_resp_rdata;
            end else if (resp_timeout) begin
                resp_rdata <= '0;
            end else begin
                resp_rdata <= read_data;
            end
            resp_error <= resp_timeout && !resp_from_fill;
        end
    end

    // **********************************************************************
    // Parent request register
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            parent_req_valid <= 1'b0;
        end else if (produce_parent) begin
            parent_req_valid <= 1'b1;
        end else if (parent_req_ready) begin
            parent_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (produce_parent) begin
            parent_req_op    <= stage_op;
            parent_req_addr  <= stage_addr;
            parent_req_wdata <= stage_wdata; // Unused by the parent on reads.
        end
    end

    // Fill data and timeout errors land in an empty response slot.
    assert property (@(posedge clk) disable iff (rst)
        resp_from_fill || resp_timeout |-> !resp_valid && !produce_resp)
        else $error("Fill or timeout response over a busy response slot.");

endmodule

`default_nettype wire

/* hdl/cache_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_decode (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          req_valid,
    input  cache_pkg::cache_op_t          req_op,
    input  logic [`CACHE_ADDR_WIDTH-1:0]  req_addr,
    input  logic [`CACHE_DATA_WIDTH-1:0]  req_wdata,
    output logic                          req_ready,

    input  logic                          accept_enable,

    output logic [`CACHE_INDEX_BITS-1:0]  read_index,
    input  logic [`CACHE_TAG_BITS-1:0]    read_tag,
    input  logic                          read_valid_bit,

    output logic                          stage_valid,
    output cache_pkg::cache_op_t          stage_op,
    output logic [`CACHE_ADDR_WIDTH-1:0]  stage_addr,
    output logic [`CACHE_DATA_WIDTH-1:0]  stage_wdata,
    output logic                          stage_hit,
    input  logic                          stage_hold
);

    logic ready_armed;
    logic accept;

    // Keeps req_ready low for the first cycle out of reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_armed <= 1'b0;
        end else begin
            ready_armed <= 1'b1;
        end
    end

    assign req_ready = ready_armed && accept_enable && !stage_hold;
    assign accept    = req_valid && req_ready;

    // A held stage keeps its own line on the store read port.
    assign read_index = stage_hold ? stage_addr[`CACHE_INDEX_BITS-1:0]
                                   : req_addr[`CACHE_INDEX_BITS-1:0];

    // **********************************************************************
    // Request stage
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (!stage_hold) begin
            stage_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_op    <= req_op;
            stage_addr  <= req_addr;
            stage_wdata <= req_wdata;
        end
    end

    assign stage_hit = read_valid_bit &&
                       (read_tag == stage_addr[`CACHE_ADDR_WIDTH-1:`CACHE_INDEX_BITS]);

    // Writes and misses in the stage hold off new requests.
    assert property (@(posedge clk) disable iff (rst)
        stage_valid && (stage_op == cache_pkg::CACHE_OP_WRITE || !stage_hit) |-> !req_ready)
        else $error("req_ready high behind a staged write or miss.");

endmodule

`default_nettype wire

/* hdl/cache_store.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_defines.svh"

module cache_store (
    input  logic                         clk,
    input  logic                         rst,

    input  logic [`CACHE_INDEX_BITS-1:0] read_index,
    output logic [`CACHE_TAG_BITS-1:0]   read_tag,
    output logic                         read_valid_bit,
    output logic [`CACHE_DATA_WIDTH-1:0] read_data,

    input  logic                         write_enable,
    input  logic [`CACHE_INDEX_BITS-1:0] write_index,
    input  logic [`CACHE_TAG_BITS-1:0]   write_tag,
    input  logic [`CACHE_DATA_WIDTH-1:0] write_data
);

    logic [`CACHE_TAG_BITS-1:0]   tag_mem  [`CACHE_LINES];
    logic [`CACHE_DATA_WIDTH-1:0] data_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]      valid_bits;
    logic                         same_line;

    assign same_line = write_enable && (write_index == read_index);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0; // Whole cache invalid at once.
        end else if (write_enable) begin
            valid_bits[write_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            tag_mem[write_index]  <= write_tag;
            data_mem[write_index] <= write_data;
        end
    end

    // Registered read, new data wins on a collision.
    always_ff @(posedge clk) begin
        if (same_line) begin
            read_tag  <= write_tag;
            read_data <= write_data;
        end else begin
            read_tag  <= tag_mem[read_index];
            read_data <= data_mem[read_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_valid_bit <= 1'b0;
        end else begin
            read_valid_bit <= same_line || valid_bits[read_index];
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // Child and parent request opcode.
    typedef enum logic {
        CACHE_OP_READ  = 1'b0,
        CACHE_OP_WRITE = 1'b1
    } cache_op_t;

    // Control FSM states.
    typedef enum logic [1:0] {
        STATE_IDLE         = 2'd0,
        STATE_PARENT_WRITE = 2'd1, // Write forwarded, waiting for accept.
        STATE_PARENT_READ  = 2'd2, // Miss issued, waiting for accept.
        STATE_FILL_WAIT    = 2'd3
    } cache_state_t;

endpackage

`default_nettype wire

/* hdl/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Word address and data widths.
`define CACHE_ADDR_WIDTH 16
`define CACHE_DATA_WIDTH 32

// Direct mapped, one word per line.
`define CACHE_INDEX_BITS 4
`define CACHE_LINES (1 << `CACHE_INDEX_BITS)
`define CACHE_TAG_BITS (`CACHE_ADDR_WIDTH - `CACHE_INDEX_BITS)

// Cycles a fill may wait for the parent.
`define CACHE_FILL_TIMEOUT 64

`endif
